/* masked_pwm_pkg.sv */
// shared definitions for the masked pointwise multiply-accumulate engine
// modulus, share widths, pipeline latencies, Wishbone address map,
// mask generator constants, controller states and modular helpers

`default_nettype none

package masked_pwm_pkg;

    // ML-DSA prime and the width of one arithmetic share
    localparam int COEF_W = 23;
    localparam logic [COEF_W-1:0] Q = 23'd8380417;

    // one run covers eight coefficients
    localparam int N_COEF = 8;
    localparam int IDX_W = 3;

    // multiplier depth, adder depth and the accumulate path depth
    localparam int MUL_LAT = 3;
    localparam int ADD_LAT = 1;
    localparam int PWM_LAT_ACC = MUL_LAT + ADD_LAT;

    // run counter must hold N_COEF + PWM_LAT_ACC
    localparam int CNT_W = 4;

    // Wishbone word address is {bank, index}
    localparam int WB_DW = 32;
    localparam int WB_AW = 7;
    localparam int BANK_W = WB_AW - IDX_W;

    localparam logic [BANK_W-1:0] BANK_CSR = 4'd0;
    localparam logic [BANK_W-1:0] BANK_U0 = 4'd1;
    localparam logic [BANK_W-1:0] BANK_U1 = 4'd2;
    localparam logic [BANK_W-1:0] BANK_V0 = 4'd3;
    localparam logic [BANK_W-1:0] BANK_V1 = 4'd4;
    localparam logic [BANK_W-1:0] BANK_W0 = 4'd5;
    localparam logic [BANK_W-1:0] BANK_W1 = 4'd6;
    localparam logic [BANK_W-1:0] BANK_R0 = 4'd7;
    localparam logic [BANK_W-1:0] BANK_R1 = 4'd8;

    // registers inside the CSR bank and their bit positions
    localparam logic [IDX_W-1:0] CSR_CTRL = 3'd0;
    localparam logic [IDX_W-1:0] CSR_STATUS = 3'd1;
    localparam int CTRL_START = 0;
    localparam int CTRL_ACC = 1;
    localparam int STAT_BUSY = 0;
    localparam int STAT_DONE = 1;

    // Galois LFSR for the mask words, x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] RNG_SEED = 32'h1d87_a5c3;
    localparam logic [31:0] RNG_TAPS = 32'h8020_0003;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_DONE
    } pwm_state_e;

    // one conditional subtraction brings a value below 2Q into range
    function automatic logic [COEF_W-1:0] cond_sub_q(input logic [COEF_W-1:0] x);
        return (x >= Q) ? x - Q : x;
    endfunction

    // reduces a sum of three residues, which stays below 3Q
    function automatic logic [COEF_W-1:0] reduce_3q(input logic [COEF_W+1:0] x);
        logic [COEF_W+1:0] y;
        y = x;
        if (y >= 2 * Q) begin
            y = y - 2 * Q;
        end else if (y >= Q) begin
            y = y - Q;
        end
        return y[COEF_W-1:0];
    endfunction

endpackage

`default_nettype wire

/* mask_rng.sv */
// mask generator for the share refresh
// a 32-bit Galois LFSR jumps 64 steps per cycle, so the two masks of a
// cycle and those of the next cycle never reuse a state bit

`timescale 1ns/1ps
`default_nettype none

module mask_rng import masked_pwm_pkg::*; (
    input wire clk,
    input wire reset,
    output logic [COEF_W-1:0] rnd0,
    output logic [COEF_W-1:0] rnd1
);

    logic [31:0] lfsr;
    logic [31:0] lfsr_mid;

    // 32 single steps unrolled into an xor network
    function automatic logic [31:0] step32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        for (int i = 0; i < 32; i++) begin
            x = x[0] ? ((x >> 1) ^ RNG_TAPS) : (x >> 1);
        end
        return x;
    endfunction

    assign lfsr_mid = step32(lfsr);

    always_ff @(posedge clk) begin
        if (reset) begin
            lfsr <= RNG_SEED;
        end else begin
            lfsr <= step32(lfsr_mid);
        end
    end

    // 23 bits land below 2Q, so one subtraction is enough
    assign rnd0 = cond_sub_q(lfsr[COEF_W-1:0]);
    assign rnd1 = cond_sub_q(lfsr_mid[COEF_W-1:0]);

endmodule

`default_nettype wire

/* masked_mul_shares.sv */
// masked modular multiplier for two-share operands
// stage one forms the four cross products, stage two reduces them modulo
// Q and stage three folds them into two output shares refreshed by rnd
// m0 + m1 equals (u0 + u1)(v0 + v1) modulo Q

`timescale 1ns/1ps
`default_nettype none

module masked_mul_shares import masked_pwm_pkg::*; (
    input wire clk,
    input wire reset,
    input wire [COEF_W-1:0] u0,
    input wire [COEF_W-1:0] u1,
    input wire [COEF_W-1:0] v0,
    input wire [COEF_W-1:0] v1,
    input wire [COEF_W-1:0] rnd,
    output logic [COEF_W-1:0] m0,
    output logic [COEF_W-1:0] m1
);

    // cross products in the order u0v0, u0v1, u1v0, u1v1
    logic [2*COEF_W-1:0] prod [4];
    logic [COEF_W-1:0] prod_red [4];

    // stage one, full width products of each share pair
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 4; i++) begin
                prod[i] <= '0;
            end
        end else begin
            prod[0] <= u0 * v0;
            prod[1] <= u0 * v1;
            prod[2] <= u1 * v0;
            prod[3] <= u1 * v1;
        end
    end

    // stage two, every cross term is reduced on its own
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 4; i++) begin
                prod_red[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 4; i++) begin
                prod_red[i] <= COEF_W'(prod[i] % Q);
            end
        end
    end

    // stage three, the u0 terms go to share 0 and the u1 terms to share 1
    // the mask is added on one side and taken off the other, so neither
    // register ever carries the unmasked product
    always_ff @(posedge clk) begin
        if (reset) begin
            m0 <= '0;
            m1 <= '0;
        end else begin
            m0 <= reduce_3q(prod_red[0] + prod_red[1] + rnd);
            m1 <= reduce_3q(prod_red[2] + prod_red[3] + (Q - rnd));
        end
    end

endmodule

`default_nettype wire

/* masked_add_shares.sv */
// masked modular adder for two-share operands
// one register stage, with a fresh mask moved from share 1 to share 0
// so the output shares are unrelated to the input shares

`timescale 1ns/1ps
`default_nettype none

module masked_add_shares import masked_pwm_pkg::*; (
    input wire clk,
    input wire reset,
    input wire [COEF_W-1:0] a0,
    input wire [COEF_W-1:0] a1,
    input wire [COEF_W-1:0] b0,
    input wire [COEF_W-1:0] b1,
    input wire [COEF_W-1:0] rnd,
    output logic [COEF_W-1:0] s0,
    output logic [COEF_W-1:0] s1
);

    // the share sum stays (a + b) mod Q since rnd cancels out
    always_ff @(posedge clk) begin
        if (reset) begin
            s0 <= '0;
            s1 <= '0;
        end else begin
            s0 <= reduce_3q(a0 + b0 + rnd);
            s1 <= reduce_3q(a1 + b1 + (Q - rnd));
        end
    end

endmodule

`default_nettype wire

/* masked_pwm.sv */
// masked pointwise multiply with optional accumulate
// the product of the u and v shares is always added to the w shares,
// which travel through a delay line matched to the multiplier depth
// accumulate only picks which result reaches the output

`timescale 1ns/1ps
`default_nettype none

module masked_pwm import masked_pwm_pkg::*; (
    input wire clk,
    input wire reset,
    input wire accumulate,
    input wire [COEF_W-1:0] u0,
    input wire [COEF_W-1:0] u1,
    input wire [COEF_W-1:0] v0,
    input wire [COEF_W-1:0] v1,
    input wire [COEF_W-1:0] w0,
    input wire [COEF_W-1:0] w1,
    input wire [COEF_W-1:0] rnd0,
    input wire [COEF_W-1:0] rnd1,
    output logic [COEF_W-1:0] res0,
    output logic [COEF_W-1:0] res1
);

    logic [COEF_W-1:0] mul0;
    logic [COEF_W-1:0] mul1;
    logic [COEF_W-1:0] acc0;
    logic [COEF_W-1:0] acc1;
    logic [COEF_W-1:0] w0_dly [MUL_LAT];
    logic [COEF_W-1:0] w1_dly [MUL_LAT];

    // the multiplier and the adder each get their own mask word
    masked_mul_shares mul_i (
        .clk(clk),
        .reset(reset),
        .u0(u0),
        .u1(u1),
        .v0(v0),
        .v1(v1),
        .rnd(rnd0),
        .m0(mul0),
        .m1(mul1)
    );

    // w shares arrive with their coefficient index and must wait for the product
    always_ff @(posedge clk) begin
        w0_dly[0] <= w0;
        w1_dly[0] <= w1;
        for (int i = 1; i < MUL_LAT; i++) begin
            w0_dly[i] <= w0_dly[i-1];
            w1_dly[i] <= w1_dly[i-1];
        end
    end

    masked_add_shares add_i (
        .clk(clk),
        .reset(reset),
        .a0(mul0),
        .a1(mul1),
        .b0(w0_dly[MUL_LAT-1]),
        .b1(w1_dly[MUL_LAT-1]),
        .rnd(rnd1),
        .s0(acc0),
        .s1(acc1)
    );

    // the write-back timing follows the same select, one cycle later with accumulate
    assign res0 = accumulate ? acc0 : mul0;
    assign res1 = accumulate ? acc1 : mul1;

endmodule

`default_nettype wire

/* pwm_step_counter.sv */
// run timer for one pass over the coefficients
// the count opens the issue window for the first N_COEF cycles and the
// write-back window once the datapath latency has passed

`timescale 1ns/1ps
`default_nettype none

module pwm_step_counter import masked_pwm_pkg::*; (
    input wire clk,
    input wire reset,
    input wire clear,
    input wire run,
    input wire acc_mode,
    output logic issue_en,
    output logic [IDX_W-1:0] issue_idx,
    output logic wr_en,
    output logic [IDX_W-1:0] wr_idx,
    output logic last
);

    logic [CNT_W-1:0] cnt;
    logic [CNT_W-1:0] lat;

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            cnt <= '0;
        end else if (run) begin
            cnt <= cnt + 1'b1;
        end
    end

    // acc_mode is held by the register block for the whole run
    assign lat = acc_mode ? CNT_W'(PWM_LAT_ACC) : CNT_W'(MUL_LAT);

    assign issue_en = run && (cnt < CNT_W'(N_COEF));
    assign issue_idx = cnt[IDX_W-1:0];

    // the result for index i leaves the datapath lat cycles after its issue
    assign wr_en = run && (cnt >= lat);
    assign wr_idx = IDX_W'(cnt - lat);

    assign last = run && (cnt == CNT_W'(N_COEF) + lat - 1'b1);

endmodule

`default_nettype wire

/* pwm_ctrl_fsm.sv */
// run controller
// a start is taken from idle or done, the run ends on the counter's
// last pulse and done then holds until the next accepted start

`timescale 1ns/1ps
`default_nettype none

module pwm_ctrl_fsm import masked_pwm_pkg::*; (
    input wire clk,
    input wire reset,
    input wire start,
    input wire last,
    output logic clear,
    output logic run,
    output logic busy,
    output logic done
);

    pwm_state_e state;
    pwm_state_e state_nxt;

    // starts that arrive during a run are dropped here and nowhere else
    assign clear = start && (state != ST_RUN);

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (clear) begin
                    state_nxt = ST_RUN;
                end
            end
            ST_RUN: begin
                if (last) begin
                    state_nxt = ST_DONE;
                end
            end
            ST_DONE: begin
                // a new start clears done as it enters the run
                if (clear) begin
                    state_nxt = ST_RUN;
                end
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // the flags follow the state directly
    assign run = (state == ST_RUN);
    assign busy = (state == ST_RUN);
    assign done = (state == ST_DONE);

endmodule

`default_nettype wire

/* pwm_wb_regs.sv */
// Wishbone classic slave for the engine
// decodes {bank, index}, acknowledges every access after one wait cycle,
// holds CTRL and STATUS, the six operand share memories feeding the
// datapath and the two result share memories filled during a run

`timescale 1ns/1ps
`default_nettype none

module pwm_wb_regs import masked_pwm_pkg::*; (
    input wire clk,
    input wire reset,
    input wire wb_cyc,
    input wire wb_stb,
    input wire wb_we,
    input wire [WB_AW-1:0] wb_adr,
    input wire [WB_DW-1:0] wb_dat_w,
    output logic [WB_DW-1:0] wb_dat_r,
    output logic wb_ack,
    input wire busy,
    input wire done,
    input wire [IDX_W-1:0] issue_idx,
    input wire wr_en,
    input wire [IDX_W-1:0] wr_idx,
    input wire [COEF_W-1:0] res0,
    input wire [COEF_W-1:0] res1,
    output logic start,
    output logic acc_mode,
    output logic [COEF_W-1:0] u0,
    output logic [COEF_W-1:0] u1,
    output logic [COEF_W-1:0] v0,
    output logic [COEF_W-1:0] v1,
    output logic [COEF_W-1:0] w0,
    output logic [COEF_W-1:0] w1
);

    // operand banks U0 to W1 in bank order, results R0 and R1
    logic [COEF_W-1:0] op_mem [6][N_COEF];
    logic [COEF_W-1:0] res_mem [2][N_COEF];

    logic [BANK_W-1:0] bank;
    logic [IDX_W-1:0] idx;
    logic [2:0] op_sel;
    logic access;
    logic wr_stb;
    logic is_op;
    logic ctrl_wr;
    logic [WB_DW-1:0] rd_data;

    assign bank = wb_adr[WB_AW-1:IDX_W];
    assign idx = wb_adr[IDX_W-1:0];
    assign op_sel = 3'(bank - BANK_U0);
    assign is_op = (bank >= BANK_U0) && (bank <= BANK_W1);

    // an access is taken in the cycle before ack, ack then drops again
    assign access = wb_cyc && wb_stb && !wb_ack;
    assign wr_stb = access && wb_we;
    assign ctrl_wr = wr_stb && (bank == BANK_CSR) && (idx == CSR_CTRL);

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack <= 1'b0;
            start <= 1'b0;
            acc_mode <= 1'b0;
        end else begin
            wb_ack <= access;
            start <= ctrl_wr && wb_dat_w[CTRL_START];
            // mode stays fixed while a run depends on its latency
            if (ctrl_wr && !busy) begin
                acc_mode <= wb_dat_w[CTRL_ACC];
            end
        end
    end

    // host writes to operands only land between runs
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int b = 0; b < 6; b++) begin
                for (int i = 0; i < N_COEF; i++) begin
                    op_mem[b][i] <= '0;
                end
            end
        end else if (wr_stb && is_op && !busy) begin
            op_mem[op_sel][idx] <= wb_dat_w[COEF_W-1:0];
        end
    end

    // result shares come from the datapath write-back only
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int b = 0; b < 2; b++) begin
                for (int i = 0; i < N_COEF; i++) begin
                    res_mem[b][i] <= '0;
                end
            end
        end else if (wr_en) begin
            res_mem[0][wr_idx] <= res0;
            res_mem[1][wr_idx] <= res1;
        end
    end

    // the datapath reads the coefficient at issue_idx without a register
    assign u0 = op_mem[0][issue_idx];
    assign u1 = op_mem[1][issue_idx];
    assign v0 = op_mem[2][issue_idx];
    assign v1 = op_mem[3][issue_idx];
    assign w0 = op_mem[4][issue_idx];
    assign w1 = op_mem[5][issue_idx];

    always_comb begin
        rd_data = '0;
        if (bank == BANK_CSR) begin
            if (idx == CSR_CTRL) begin
                rd_data[CTRL_ACC] = acc_mode;
            end else if (idx == CSR_STATUS) begin
                rd_data[STAT_BUSY] = busy;
                rd_data[STAT_DONE] = done;
            end
        end else if (is_op) begin
            rd_data[COEF_W-1:0] = op_mem[op_sel][idx];
        end else if (bank == BANK_R0) begin
            rd_data[COEF_W-1:0] = res_mem[0][idx];
        end else if (bank == BANK_R1) begin
            rd_data[COEF_W-1:0] = res_mem[1][idx];
        end
    end

    // read data is captured on the same edge that raises ack
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_dat_r <= '0;
        end else if (access) begin
            wb_dat_r <= rd_data;
        end
    end

endmodule

`default_nettype wire

/* masked_pwm_top.sv */
// top level of the masked pointwise multiply-accumulate engine
// joins the Wishbone register block, the run controller, the run timer,
// the mask generator and the masked datapath

`timescale 1ns/1ps
`default_nettype none

module masked_pwm_top import masked_pwm_pkg::*; (
    input wire clk,
    input wire reset,
    input wire wb_cyc,
    input wire wb_stb,
    input wire wb_we,
    input wire [WB_AW-1:0] wb_adr,
    input wire [WB_DW-1:0] wb_dat_w,
    output logic [WB_DW-1:0] wb_dat_r,
    output logic wb_ack
);

    logic start, acc_mode, clear, run, busy, done, last;
    logic wr_en;
    logic [IDX_W-1:0] issue_idx, wr_idx;
    logic [COEF_W-1:0] u0, u1, v0, v1, w0, w1;
    logic [COEF_W-1:0] rnd0, rnd1, res0, res1;

    pwm_wb_regs regs_i (
        .clk(clk), .reset(reset),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .busy(busy), .done(done), .issue_idx(issue_idx),
        .wr_en(wr_en), .wr_idx(wr_idx), .res0(res0), .res1(res1),
        .start(start), .acc_mode(acc_mode),
        .u0(u0), .u1(u1), .v0(v0), .v1(v1), .w0(w0), .w1(w1)
    );

    pwm_ctrl_fsm ctrl_i (
        .clk(clk), .reset(reset), .start(start), .last(last),
        .clear(clear), .run(run), .busy(busy), .done(done)
    );

    // the datapath runs every cycle, so the issue window flag has no load here
    pwm_step_counter cnt_i (
        .clk(clk), .reset(reset), .clear(clear), .run(run), .acc_mode(acc_mode),
        .issue_en(), .issue_idx(issue_idx),
        .wr_en(wr_en), .wr_idx(wr_idx), .last(last)
    );

    mask_rng rng_i (
        .clk(clk), .reset(reset), .rnd0(rnd0), .rnd1(rnd1)
    );

    masked_pwm pwm_i (
        .clk(clk), .reset(reset), .accumulate(acc_mode),
        .u0(u0), .u1(u1), .v0(v0), .v1(v1), .w0(w0), .w1(w1),
        .rnd0(rnd0), .rnd1(rnd1), .res0(res0), .res1(res1)
    );

endmodule

`default_nettype wire

/* tb_masked_pwm.sv */
// self-checking testbench for the masked pointwise multiply-accumulate engine
// loads random two-share operands over Wishbone, runs the engine with and
// without accumulate and checks the unmasked result sums against a model

`timescale 1ns/1ps
`default_nettype none

module tb_masked_pwm import masked_pwm_pkg::*; ();

    localparam int ACK_LIMIT = 16;
    localparam int DONE_POLLS = 40;

    logic clk = 1'b0;
    logic reset;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    logic [WB_AW-1:0] wb_adr;
    logic [WB_DW-1:0] wb_dat_w;
    logic [WB_DW-1:0] wb_dat_r;
    logic wb_ack;

    // operand shares as written to the DUT, results as read back
    logic [COEF_W-1:0] u0s [N_COEF];
    logic [COEF_W-1:0] u1s [N_COEF];
    logic [COEF_W-1:0] v0s [N_COEF];
    logic [COEF_W-1:0] v1s [N_COEF];
    logic [COEF_W-1:0] w0s [N_COEF];
    logic [COEF_W-1:0] w1s [N_COEF];
    logic [COEF_W-1:0] cur_r0 [N_COEF];
    logic [COEF_W-1:0] cur_r1 [N_COEF];
    logic [COEF_W-1:0] prev_r0 [N_COEF];
    logic [COEF_W-1:0] prev_r1 [N_COEF];
    logic [15:0] lfsr_state;
    int errors;
    int checks;

    masked_pwm_top masked_pwm_top_i (
        .clk(clk), .reset(reset),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
    );

    always #50 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1, the bit shifted out is s[15]
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // expected unmasked coefficient, computed from the share sums directly
    function automatic logic [COEF_W-1:0] ref_coef(input int k, input logic acc);
        longint unsigned u;
        longint unsigned v;
        longint unsigned w;
        longint unsigned r;
        u = (64'(u0s[k]) + 64'(u1s[k])) % 64'(Q);
        v = (64'(v0s[k]) + 64'(v1s[k])) % 64'(Q);
        w = (64'(w0s[k]) + 64'(w1s[k])) % 64'(Q);
        r = (u * v) % 64'(Q);
        if (acc) begin
            r = (r + w) % 64'(Q);
        end
        return COEF_W'(r);
    endfunction

    function automatic logic [WB_AW-1:0] word_addr(input int bank, input int idx);
        return {BANK_W'(bank), IDX_W'(idx)};
    endfunction

    function automatic logic [COEF_W-1:0] operand_word(input int bank, input int k);
        case (bank)
            BANK_U0: return u0s[k];
            BANK_U1: return u1s[k];
            BANK_V0: return v0s[k];
            BANK_V1: return v1s[k];
            BANK_W0: return w0s[k];
            default: return w1s[k];
        endcase
    endfunction

    task automatic check_value(input string name, input logic [WB_DW-1:0] exp_val,
                               input logic [WB_DW-1:0] got_val);
        checks++;
        if (got_val !== exp_val) begin
            errors++;
            $display("ERROR %s expected 0x%h got 0x%h", name, exp_val, got_val);
        end
    endtask

    // ends the simulation after a hang
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("checks %0d errors %0d", checks, errors + 1);
        $display("TEST FAILED");
        $finish;
    endtask

    // 23 bits, one LFSR step each, then one subtraction brings it below Q
    task automatic draw_share(output logic [COEF_W-1:0] val);
        logic [COEF_W-1:0] raw;
        raw = '0;
        for (int i = 0; i < COEF_W; i++) begin
            raw = {raw[COEF_W-2:0], lfsr_state[15]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        val = (raw >= Q) ? raw - Q : raw;
    endtask

    task automatic draw_operands(input logic new_uv, input logic new_w);
        for (int k = 0; k < N_COEF; k++) begin
            if (new_uv) begin
                draw_share(u0s[k]);
                draw_share(u1s[k]);
                draw_share(v0s[k]);
                draw_share(v1s[k]);
            end
            if (new_w) begin
                draw_share(w0s[k]);
                draw_share(w1s[k]);
            end
        end
    endtask

    // classic cycle, the slave acks one cycle after the strobe is seen
    task automatic wb_write(input logic [WB_AW-1:0] adr, input logic [WB_DW-1:0] data);
        int n;
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we <= 1'b1;
        wb_adr <= adr;
        wb_dat_w <= data;
        n = 0;
        @(negedge clk);
        while (!wb_ack && n < ACK_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!wb_ack) begin
            abort_run($sformatf("no wb_ack for the write to address 0x%h", adr));
        end else begin
            @(posedge clk);
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            wb_we <= 1'b0;
        end
    endtask

    // read data is taken at the falling edge while ack is high
    task automatic wb_read(input logic [WB_AW-1:0] adr, output logic [WB_DW-1:0] data);
        int n;
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we <= 1'b0;
        wb_adr <= adr;
        n = 0;
        @(negedge clk);
        while (!wb_ack && n < ACK_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!wb_ack) begin
            abort_run($sformatf("no wb_ack for the read of address 0x%h", adr));
        end else begin
            data = wb_dat_r;
            @(posedge clk);
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
        end
    endtask

    task automatic load_operands();
        for (int b = BANK_U0; b <= BANK_W1; b++) begin
            for (int k = 0; k < N_COEF; k++) begin
                wb_write(word_addr(b, k), WB_DW'(operand_word(b, k)));
            end
        end
    endtask

    // polls STATUS until done, noting whether busy showed up on the way
    task automatic wait_done(output logic seen_busy);
        logic [WB_DW-1:0] st;
        int n;
        seen_busy = 1'b0;
        n = 0;
        wb_read(word_addr(BANK_CSR, CSR_STATUS), st);
        while (!st[STAT_DONE] && n < DONE_POLLS) begin
            if (st[STAT_BUSY]) begin
                seen_busy = 1'b1;
            end
            wb_read(word_addr(BANK_CSR, CSR_STATUS), st);
            n++;
        end
        if (!st[STAT_DONE]) begin
            abort_run("the run never set done in STATUS");
        end
    endtask

    // the shares are only ever combined here, never inside the DUT
    task automatic compare_results(input logic acc);
        logic [WB_DW-1:0] d0;
        logic [WB_DW-1:0] d1;
        logic [WB_DW-1:0] sum;
        for (int k = 0; k < N_COEF; k++) begin
            wb_read(word_addr(BANK_R0, k), d0);
            wb_read(word_addr(BANK_R1, k), d1);
            cur_r0[k] = d0[COEF_W-1:0];
            cur_r1[k] = d1[COEF_W-1:0];
            sum = (d0 + d1) % WB_DW'(Q);
            check_value($sformatf("r_sum[%0d]", k), WB_DW'(ref_coef(k, acc)), sum);
        end
    endtask

    initial begin
        logic [WB_DW-1:0] rd;
        logic seen_busy;
        int same;
        reset = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        lfsr_state = 16'd71;
        errors = 0;
        checks = 0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        // everything visible to the host is clear after reset
        wb_read(word_addr(BANK_CSR, CSR_STATUS), rd);
        check_value("status", '0, rd);
        wb_read(word_addr(BANK_CSR, CSR_CTRL), rd);
        check_value("ctrl", '0, rd);
        for (int k = 0; k < N_COEF; k++) begin
            wb_read(word_addr(BANK_R0, k), rd);
            check_value($sformatf("r0[%0d]", k), '0, rd);
            wb_read(word_addr(BANK_R1, k), rd);
            check_value($sformatf("r1[%0d]", k), '0, rd);
        end

        // operand words read back as written
        draw_operands(1'b1, 1'b1);
        load_operands();
        for (int b = BANK_U0; b <= BANK_W1; b++) begin
            for (int k = 0; k < N_COEF; k++) begin
                wb_read(word_addr(b, k), rd);
                check_value($sformatf("op[%0d][%0d]", b, k), WB_DW'(operand_word(b, k)), rd);
            end
        end

        // plain multiply, busy must be seen before done
        wb_write(word_addr(BANK_CSR, CSR_CTRL), 32'h1);
        wait_done(seen_busy);
        check_value("busy_seen", 32'h1, WB_DW'(seen_busy));
        compare_results(1'b0);

        // same u and v with a fresh addend
        draw_operands(1'b0, 1'b1);
        load_operands();
        wb_write(word_addr(BANK_CSR, CSR_CTRL), 32'h3);
        wait_done(seen_busy);
        compare_results(1'b1);

        // new operands, started from done, then the same operands again
        draw_operands(1'b1, 1'b1);
        load_operands();
        wb_write(word_addr(BANK_CSR, CSR_CTRL), 32'h3);
        wb_read(word_addr(BANK_CSR, CSR_STATUS), rd);
        check_value("status", 32'h1, rd);
        wait_done(seen_busy);
        compare_results(1'b1);
        prev_r0 = cur_r0;
        prev_r1 = cur_r1;
        wb_write(word_addr(BANK_CSR, CSR_CTRL), 32'h3);
        wait_done(seen_busy);
        compare_results(1'b1);
        same = 0;
        for (int k = 0; k < N_COEF; k++) begin
            if (cur_r0[k] == prev_r0[k] && cur_r1[k] == prev_r1[k]) begin
                same++;
            end
        end
        checks++;
        if (same != 0) begin
            errors++;
            $display("masks were not refreshed, %0d share pairs repeat the last run", same);
        end

        // a second start with the accumulate bit arrives mid-run and is dropped
        wb_write(word_addr(BANK_CSR, CSR_CTRL), 32'h1);
        wb_read(word_addr(BANK_CSR, CSR_STATUS), rd);
        check_value("status", 32'h1, rd);
        wb_write(word_addr(BANK_CSR, CSR_CTRL), 32'h3);
        wait_done(seen_busy);
        compare_results(1'b0);
        wb_read(word_addr(BANK_CSR, CSR_STATUS), rd);
        check_value("status", 32'h2, rd);
        wb_read(word_addr(BANK_CSR, CSR_CTRL), rd);
        check_value("ctrl", '0, rd);

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* masked_pwm.f */
masked_pwm_pkg.sv
mask_rng.sv
masked_mul_shares.sv
masked_add_shares.sv
masked_pwm.sv
pwm_step_counter.sv
pwm_ctrl_fsm.sv
pwm_wb_regs.sv
masked_pwm_top.sv
tb_masked_pwm.sv
